//--- Makefile
# Verilator build and run for the ALU unit testbench

TOP = alu_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f flist.f -o alu_sim

run: compile
	./obj_dir/alu_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/alu_unit_tb.sv
// Self-checking testbench for the ALU unit with random credit stalls on both sides
module alu_unit_tb
  import alu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_VEC    = 64;
  localparam int WAIT_LIMIT = 400;

  logic             clk_i;
  logic             reset_i;
  logic             req_valid_i;
  alu_op_e          req_op_i;
  logic [XLEN-1:0]  req_operand_a_i;
  logic [XLEN-1:0]  req_operand_b_i;
  logic [TAG_W-1:0] req_tag_i;
  logic             req_credit_o;
  logic             res_valid_o;
  logic [XLEN-1:0]  res_data_o;
  logic             res_branch_o;
  logic [TAG_W-1:0] res_tag_o;
  logic             res_credit_i;

  // Five words per vector for op, A, B, result and branch flag
  logic [31:0]      vec_mem [5*MAX_VEC];
  int               num_vec;

  // Expected results indexed by tag
  alu_op_e          exp_op     [2**TAG_W];
  logic [XLEN-1:0]  exp_data   [2**TAG_W];
  logic             exp_branch [2**TAG_W];
  int               exp_vec    [2**TAG_W];
  logic [TAG_W-1:0] issue_tags [$];

  logic [15:0]      lfsr;
  int               up_credits;
  int               granted_credits;
  int               owed_credits;
  int               issued;
  int               received;
  int               checks;
  int               value_errors;
  int               protocol_errors;
  bit               timed_out;
  int               wait_cycles;

  alu_unit uut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (req_valid_i),
    .req_op_i        (req_op_i),
    .req_operand_a_i (req_operand_a_i),
    .req_operand_b_i (req_operand_b_i),
    .req_tag_i       (req_tag_i),
    .req_credit_o    (req_credit_o),
    .res_valid_o     (res_valid_o),
    .res_data_o      (res_data_o),
    .res_branch_o    (res_branch_o),
    .res_tag_o       (res_tag_o),
    .res_credit_i    (res_credit_i)
  );

  always #2 clk_i = ~clk_i;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic next_random_bit();
    logic feedback;
    feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr     = {lfsr[14:0], feedback};
    return feedback;
  endfunction

  function automatic string vector_label(logic [TAG_W-1:0] tag);
    return $sformatf("vector %0d %s", exp_vec[tag], exp_op[tag].name());
  endfunction

  task automatic check_quiet_outputs(string phase);
    checks++;
    assert (!res_valid_o && !req_credit_o) else begin
      protocol_errors++;
      $display("res_valid_o or req_credit_o was high %s", phase);
    end
  endtask

  task automatic check_result();
    logic [TAG_W-1:0] tag;
    checks++;
    assert (granted_credits > 0) else begin
      protocol_errors++;
      $display("A result came out while no downstream credit was granted");
    end
    if (granted_credits > 0) begin
      granted_credits--;
    end
    owed_credits++;
    received++;
    checks++;
    assert (issue_tags.size() > 0) else begin
      protocol_errors++;
      $display("A result came out with no request outstanding");
    end
    if (issue_tags.size() > 0) begin
      tag = issue_tags.pop_front();
      checks += 3;
      assert (res_tag_o == tag) else begin
        value_errors++;
        $display("ERROR %s tag: expected %h, actual %h", vector_label(tag), tag, res_tag_o);
      end
      assert (res_data_o == exp_data[tag]) else begin
        value_errors++;
        $display("ERROR %s data: expected %h, actual %h", vector_label(tag),
                 exp_data[tag], res_data_o);
      end
      assert (res_branch_o == exp_branch[tag]) else begin
        value_errors++;
        $display("ERROR %s branch: expected %b, actual %b", vector_label(tag),
                 exp_branch[tag], res_branch_o);
      end
    end
  endtask

  // One clock of monitoring and consumer credit returns
  task automatic step_cycle();
    @(negedge clk_i);
    res_credit_i = 1'b0;
    if (req_credit_o) begin
      up_credits++;
      checks++;
      assert (up_credits <= REQ_DEPTH) else begin
        protocol_errors++;
        $display("More upstream credits came back than were spent");
      end
    end
    if (res_valid_o) begin
      check_result();
    end
    // Consumer frees its buffer at random
    if (owed_credits > 0 && next_random_bit()) begin
      res_credit_i = 1'b1;
      owed_credits--;
      granted_credits++;
    end
  endtask

  task automatic issue_request(int idx);
    logic [TAG_W-1:0] tag;
    tag             = TAG_W'(issued);
    exp_op[tag]     = alu_op_e'(vec_mem[5*idx][5:0]);
    exp_data[tag]   = vec_mem[5*idx+3];
    exp_branch[tag] = vec_mem[5*idx+4][0];
    exp_vec[tag]    = idx;
    issue_tags.push_back(tag);
    req_valid_i     = 1'b1;
    req_op_i        = exp_op[tag];
    req_operand_a_i = vec_mem[5*idx+1];
    req_operand_b_i = vec_mem[5*idx+2];
    req_tag_i       = tag;
    up_credits--;
    issued++;
  endtask

  initial begin
    clk_i           = 1'b0;
    reset_i         = 1'b1;
    req_valid_i     = 1'b0;
    req_op_i        = ADD;
    req_operand_a_i = '0;
    req_operand_b_i = '0;
    req_tag_i       = '0;
    res_credit_i    = 1'b0;
    lfsr            = 16'd14;
    up_credits      = REQ_DEPTH;
    granted_credits = RES_CREDITS_INIT;
    owed_credits    = 0;
    issued          = 0;
    received        = 0;
    checks          = 0;
    value_errors    = 0;
    protocol_errors = 0;
    timed_out       = 1'b0;

    // Words past the end of the file keep an address pattern above any op code
    foreach (vec_mem[i]) begin
      vec_mem[i] = 32'hdead_0000 | 32'(i);
    end
    $readmemh("dv/alu_vectors.txt", vec_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && vec_mem[5*num_vec] < 32'hff) begin
      num_vec++;
    end
    checks++;
    assert (num_vec > 0) else begin
      protocol_errors++;
      $display("No vectors were read from dv/alu_vectors.txt");
    end

    // ----------------------------------------
    // Reset
    // ----------------------------------------
    repeat (4) begin
      @(negedge clk_i);
      check_quiet_outputs("during reset");
    end
    reset_i = 1'b0;
    @(negedge clk_i);
    check_quiet_outputs("right after reset");

    // ----------------------------------------
    // Issue with random gaps
    // ----------------------------------------
    wait_cycles = 0;
    while (issued < num_vec && !timed_out) begin
      step_cycle();
      req_valid_i = 1'b0;
      if (up_credits > 0 && next_random_bit()) begin
        issue_request(issued);
        wait_cycles = 0;
      end else begin
        wait_cycles++;
        if (wait_cycles > WAIT_LIMIT) begin
          timed_out = 1'b1;
          $display("Timeout while waiting to issue vector %0d, no upstream credit", issued);
        end
      end
    end

    // Drain results
    wait_cycles = 0;
    while (received < num_vec && !timed_out) begin
      step_cycle();
      req_valid_i = 1'b0;
      wait_cycles++;
      if (wait_cycles > WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("Timeout while waiting for results, %0d of %0d arrived", received, num_vec);
      end
    end

    wait_cycles = 0;
    while (up_credits != REQ_DEPTH && !timed_out) begin
      step_cycle();
      wait_cycles++;
      if (wait_cycles > WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("Timeout while waiting for upstream credits, %0d held", up_credits);
      end
    end

    // A few idle cycles catch late or extra traffic
    if (!timed_out) begin
      repeat (8) begin
        step_cycle();
      end
      checks += 2;
      assert (received == num_vec) else begin
        protocol_errors++;
        $display("Got %0d results for %0d requests", received, num_vec);
      end
      assert (up_credits == REQ_DEPTH) else begin
        protocol_errors++;
        $display("Upstream credits ended at %0d instead of the queue depth", up_credits);
      end
    end

    $display("Checks: %0d, value errors: %0d, protocol errors: %0d, timeouts: %0d",
             checks, value_errors, protocol_errors, timed_out);
    if (timed_out || value_errors != 0 || protocol_errors != 0) begin
      $display("SIMULATION FAILED");
    end else begin
      $display("SIMULATION PASSED");
    end
    $finish;
  end

endmodule

//--- dv/alu_vectors.txt
// Columns: op, operand A, operand B, expected result, expected branch flag (all hex)
// Op codes follow alu_op_e, an op of ff ends the list
00 00000005 00000003 00000008 1
00 7fffffff 00000001 80000000 1
01 00000003 00000005 fffffffe 1
02 f0f0ff00 0ff00ff0 00f00f00 1
03 f0f0ff00 0ff00ff0 fff0fff0 1
04 f0f0ff00 0ff00ff0 ff00f0f0 1
05 f0f0ff00 0ff00ff0 f000f000 1
06 f0f0ff00 0ff00ff0 f0ffff0f 1
07 f0f0ff00 0ff00ff0 00ff0f0f 1
08 00000001 0000001f 80000000 1
09 80000000 00000004 08000000 1
0a 80000000 00000004 f8000000 1
0b ffffffff 00000001 00000001 1
0c ffffffff 00000001 00000000 1
0d 12345678 12345678 00000000 1
0d 12345678 12345679 00000000 0
0e 12345678 12345679 00000000 1
0f 80000000 00000001 00000000 1
10 80000000 00000001 00000000 0
11 80000000 00000001 00000000 0
12 80000000 00000001 00000000 1
11 00000005 00000005 00000000 1
13 ffffff00 00000010 ffffff00 1
14 ffffff00 00000010 00000010 1
15 ffffff00 00000010 00000010 1
16 ffffff00 00000010 ffffff00 1
17 00010000 00000000 0000000f 1
17 00000000 00000000 00000020 1
18 00010000 00000000 00000010 1
19 f0f0000f 00000000 0000000c 1
1a 00000080 00000000 ffffff80 1
1b 12348000 00000000 ffff8000 1
1c ffff8765 00000000 00008765 1
1d 80000001 00000004 00000018 1
1e 80000001 00000004 18000000 1
1f 00120300 00000000 00ffff00 1
20 12345678 00000000 78563412 1
ff 00000000 00000000 00000000 0

//--- flist.f
verilog/alu_pkg.sv
verilog/credit_fifo.sv
verilog/alu_shifter.sv
verilog/alu_bitcount.sv
verilog/alu_datapath.sv
verilog/alu_egress.sv
verilog/alu_unit.sv
dv/alu_unit_tb.sv

//--- verilog/alu_bitcount.sv
// Leading zero, trailing zero and population count unit
module alu_bitcount
  import alu_pkg::*;
(
  input  logic [XLEN-1:0] operand_i,
  input  alu_op_e         op_i,
  output logic [5:0]      count_o
);

  logic [XLEN-1:0] scan_word;
  logic [5:0]      lead_zeros;
  logic [5:0]      pop_count;

  // CTZ is CLZ of the bit-reversed word
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      scan_word[i] = (op_i == CTZ) ? operand_i[XLEN-1-i] : operand_i[i];
    end
  end

  // ----------------------------------------
  // Leading zeros
  // ----------------------------------------
  // Walk up from bit 0 so the highest set bit is the last to hit,
  // an all-zero word keeps the full width
  always_comb begin
    lead_zeros = 6'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
      if (scan_word[i]) begin
        lead_zeros = 6'(XLEN - 1 - i);
      end
    end
  end

  // ----------------------------------------
  // Population count
  // ----------------------------------------
  always_comb begin
    pop_count = '0;
    for (int i = 0; i < XLEN; i++) begin
      pop_count = pop_count + {5'b0, operand_i[i]};
    end
  end

  assign count_o = (op_i == CPOP) ? pop_count : lead_zeros;

endmodule

//--- verilog/alu_datapath.sv
// Two-stage ALU pipeline between the request queue and the result queue
module alu_datapath
  import alu_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  alu_req_t req_head_i,
  input  logic     req_not_empty_i,
  output logic     req_pop_o,
  input  logic     slot_credit_i,
  output logic     res_push_o,
  output alu_res_t res_data_o
);

  // Issue control
  logic [CNT_W-1:0] slot_cnt;
  logic             issue;

  // Stage 1 logic
  logic             negate_b;
  logic             signed_cmp;
  logic [XLEN-1:0]  operand_b_mod;
  logic [XLEN:0]    adder_in_a;
  logic [XLEN:0]    adder_in_b;
  logic [XLEN:0]    adder_out;
  logic             less;
  logic [XLEN-1:0]  shift_result;
  logic [5:0]       count_result;

  // Stage 1 registers
  logic             s1_valid;
  alu_op_e          s1_op;
  logic [XLEN-1:0]  s1_a;
  logic [XLEN-1:0]  s1_b;
  logic [XLEN-1:0]  s1_sum;
  logic             s1_zero;
  logic             s1_less;
  logic [XLEN-1:0]  s1_shift;
  logic [5:0]       s1_count;
  logic [TAG_W-1:0] s1_tag;

  // Stage 2
  logic [XLEN-1:0]  orcb_word;
  logic [XLEN-1:0]  rev8_word;
  logic [XLEN-1:0]  result_sel;
  logic             branch_sel;
  logic             s2_valid;
  alu_res_t         s2_res;

  // ----------------------------------------
  // Issue and result-queue slot credits
  // ----------------------------------------
  assign issue     = req_not_empty_i && (slot_cnt != '0);
  assign req_pop_o = issue;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_cnt <= CNT_W'(RES_DEPTH);
    end else begin
      case ({issue, slot_credit_i})
        2'b10:   slot_cnt <= slot_cnt - 1'b1;
        2'b01:   slot_cnt <= slot_cnt + 1'b1;
        default: slot_cnt <= slot_cnt;
      endcase
    end
  end

  // ----------------------------------------
  // Stage 1: adder, compare, shift, count
  // ----------------------------------------
  assign negate_b      = req_head_i.op inside {SUB, EQ, NE, ANDN, ORN, XNOR};
  assign operand_b_mod = req_head_i.operand_b ^ {XLEN{negate_b}};

  // Carry-in rides in the extra low bit
  assign adder_in_a = {req_head_i.operand_a, 1'b1};
  assign adder_in_b = {operand_b_mod, negate_b};
  assign adder_out  = adder_in_a + adder_in_b;

  assign signed_cmp = req_head_i.op inside {SLTS, LTS, GES, MIN, MAX};
  assign less = $signed({signed_cmp & req_head_i.operand_a[XLEN-1], req_head_i.operand_a}) <
                $signed({signed_cmp & req_head_i.operand_b[XLEN-1], req_head_i.operand_b});

  alu_shifter u_shifter (
    .operand_i (req_head_i.operand_a),
    .amount_i  (req_head_i.operand_b[4:0]),
    .op_i      (req_head_i.op),
    .result_o  (shift_result)
  );

  alu_bitcount u_bitcount (
    .operand_i (req_head_i.operand_a),
    .op_i      (req_head_i.op),
    .count_o   (count_result)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
    end
  end

  // B is kept in its possibly inverted form for the logic ops
  always_ff @(posedge clk_i) begin
    if (issue) begin
      s1_op    <= req_head_i.op;
      s1_a     <= req_head_i.operand_a;
      s1_b     <= operand_b_mod;
      s1_sum   <= adder_out[XLEN:1];
      s1_zero  <= ~|adder_out[XLEN:1];
      s1_less  <= less;
      s1_shift <= shift_result;
      s1_count <= count_result;
      s1_tag   <= req_head_i.tag;
    end
  end

  // ----------------------------------------
  // Stage 2: result select
  // ----------------------------------------
  for (genvar gi = 0; gi < XLEN / 8; gi++) begin : g_bytes
    assign orcb_word[8*gi +: 8] = {8{|s1_a[8*gi +: 8]}};
    assign rev8_word[8*gi +: 8] = s1_a[XLEN-8-8*gi +: 8];
  end

  always_comb begin
    case (s1_op)
      ADD, SUB:                 result_sel = s1_sum;
      ANDL, ANDN:               result_sel = s1_a & s1_b;
      ORL, ORN:                 result_sel = s1_a | s1_b;
      XORL, XNOR:               result_sel = s1_a ^ s1_b;
      SLL, SRL, SRA, ROL, ROR:  result_sel = s1_shift;
      SLTS, SLTU:               result_sel = {{(XLEN - 1){1'b0}}, s1_less};
      MIN, MINU:                result_sel = s1_less ? s1_a : s1_b;
      MAX, MAXU:                result_sel = s1_less ? s1_b : s1_a;
      CLZ, CTZ, CPOP:           result_sel = {{(XLEN - 6){1'b0}}, s1_count};
      SEXTB:                    result_sel = {{(XLEN - 8){s1_a[7]}}, s1_a[7:0]};
      SEXTH:                    result_sel = {{(XLEN - 16){s1_a[15]}}, s1_a[15:0]};
      ZEXTH:                    result_sel = {{(XLEN - 16){1'b0}}, s1_a[15:0]};
      ORCB:                     result_sel = orcb_word;
      REV8:                     result_sel = rev8_word;
      // Branch compares carry no result word
      default:                  result_sel = '0;
    endcase
  end

  always_comb begin
    case (s1_op)
      EQ:       branch_sel = s1_zero;
      NE:       branch_sel = ~s1_zero;
      LTS, LTU: branch_sel = s1_less;
      GES, GEU: branch_sel = ~s1_less;
      default:  branch_sel = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid) begin
      s2_res <= '{data: result_sel, branch: branch_sel, tag: s1_tag};
    end
  end

  assign res_push_o = s2_valid;
  assign res_data_o = s2_res;

endmodule

//--- verilog/alu_egress.sv
// Result queue and downstream credit counter feeding the result consumer
module alu_egress
  import alu_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             res_push_i,
  input  alu_res_t         res_data_i,
  output logic             slot_credit_o,
  input  logic             res_credit_i,
  output logic             res_valid_o,
  output logic [XLEN-1:0]  res_data_o,
  output logic             res_branch_o,
  output logic [TAG_W-1:0] res_tag_o
);

  alu_res_t         head;
  logic             not_empty;
  logic             pop;
  logic [CNT_W-1:0] credit_cnt;

  // Each pop frees a slot, its credit goes back to the datapath
  credit_fifo #(
    .payload_t (alu_res_t),
    .DEPTH     (RES_DEPTH)
  ) u_res_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (res_push_i),
    .push_data_i (res_data_i),
    .pop_i       (pop),
    .head_o      (head),
    .not_empty_o (not_empty),
    .credit_o    (slot_credit_o)
  );

  assign pop = not_empty && (credit_cnt != '0);

  // Downstream credits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_cnt <= CNT_W'(RES_CREDITS_INIT);
    end else begin
      case ({pop, res_credit_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Output register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      res_data_o   <= head.data;
      res_branch_o <= head.branch;
      res_tag_o    <= head.tag;
    end
  end

endmodule

//--- verilog/alu_pkg.sv
// ALU package with widths, queue depths, operation codes and payload types
package alu_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int unsigned XLEN             = 32;
  localparam int unsigned TAG_W            = 4;
  localparam int unsigned REQ_DEPTH        = 4;
  localparam int unsigned RES_DEPTH        = 4;
  localparam int unsigned RES_CREDITS_INIT = 2;
  // Holds any queue depth or credit total
  localparam int unsigned CNT_W            = 3;

  // ----------------------------------------
  // Operation codes
  // ----------------------------------------
  typedef enum logic [5:0] {
    // Adder
    ADD   = 6'h00,
    SUB   = 6'h01,
    // Logic, plain and with inverted B
    ANDL  = 6'h02,
    ORL   = 6'h03,
    XORL  = 6'h04,
    ANDN  = 6'h05,
    ORN   = 6'h06,
    XNOR  = 6'h07,
    // Shifts
    SLL   = 6'h08,
    SRL   = 6'h09,
    SRA   = 6'h0a,
    // Set-less-than
    SLTS  = 6'h0b,
    SLTU  = 6'h0c,
    // Branch compares
    EQ    = 6'h0d,
    NE    = 6'h0e,
    LTS   = 6'h0f,
    LTU   = 6'h10,
    GES   = 6'h11,
    GEU   = 6'h12,
    // Min and max
    MIN   = 6'h13,
    MAX   = 6'h14,
    MINU  = 6'h15,
    MAXU  = 6'h16,
    // Bit counts
    CLZ   = 6'h17,
    CTZ   = 6'h18,
    CPOP  = 6'h19,
    // Extends
    SEXTB = 6'h1a,
    SEXTH = 6'h1b,
    ZEXTH = 6'h1c,
    // Rotates and byte ops
    ROL   = 6'h1d,
    ROR   = 6'h1e,
    ORCB  = 6'h1f,
    REV8  = 6'h20
  } alu_op_e;

  // ----------------------------------------
  // Queue payloads
  // ----------------------------------------
  typedef struct packed {
    alu_op_e           op;
    logic [XLEN-1:0]   operand_a;
    logic [XLEN-1:0]   operand_b;
    logic [TAG_W-1:0]  tag;
  } alu_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   data;
    logic              branch;
    logic [TAG_W-1:0]  tag;
  } alu_res_t;

endpackage

//--- verilog/alu_shifter.sv
// Shifter and rotator built around a single arithmetic right shift
module alu_shifter
  import alu_pkg::*;
(
  input  logic [XLEN-1:0] operand_i,
  input  logic [4:0]      amount_i,
  input  alu_op_e         op_i,
  output logic [XLEN-1:0] result_o
);

  logic            shift_left;
  logic            shift_arith;
  logic            rotate;
  logic [XLEN-1:0] shift_in;
  logic [XLEN:0]   shift_ext;
  logic [XLEN:0]   shift_right;
  logic [5:0]      wrap_amount;
  logic [XLEN-1:0] wrap_bits;
  logic [XLEN-1:0] pre_result;

  // Left forms run through the right shifter on a reversed word
  assign shift_left  = op_i inside {SLL, ROL};
  assign shift_arith = (op_i == SRA);
  assign rotate      = op_i inside {ROL, ROR};

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      shift_in[i] = shift_left ? operand_i[XLEN-1-i] : operand_i[i];
    end
  end

  assign shift_ext   = {shift_arith & shift_in[XLEN-1], shift_in};
  assign shift_right = $unsigned($signed(shift_ext) >>> amount_i);

  // Bits pushed out on the right come back in at the top
  assign wrap_amount = 6'(XLEN) - {1'b0, amount_i};
  assign wrap_bits   = rotate ? (shift_in << wrap_amount) : '0;
  assign pre_result  = shift_right[XLEN-1:0] | wrap_bits;

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      result_o[i] = shift_left ? pre_result[XLEN-1-i] : pre_result[i];
    end
  end

endmodule

//--- verilog/alu_unit.sv
// Pipelined integer ALU with credit flow control on request and result sides
module alu_unit
  import alu_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             req_valid_i,
  input  alu_op_e          req_op_i,
  input  logic [XLEN-1:0]  req_operand_a_i,
  input  logic [XLEN-1:0]  req_operand_b_i,
  input  logic [TAG_W-1:0] req_tag_i,
  output logic             req_credit_o,
  output logic             res_valid_o,
  output logic [XLEN-1:0]  res_data_o,
  output logic             res_branch_o,
  output logic [TAG_W-1:0] res_tag_o,
  input  logic             res_credit_i
);

  alu_req_t req_packed;
  alu_req_t req_head;
  logic     req_not_empty;
  logic     req_pop;
  logic     slot_credit;
  logic     res_push;
  alu_res_t res_data;

  assign req_packed = '{
    op:        req_op_i,
    operand_a: req_operand_a_i,
    operand_b: req_operand_b_i,
    tag:       req_tag_i
  };

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  credit_fifo #(
    .payload_t (alu_req_t),
    .DEPTH     (REQ_DEPTH)
  ) u_req_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (req_valid_i),
    .push_data_i (req_packed),
    .pop_i       (req_pop),
    .head_o      (req_head),
    .not_empty_o (req_not_empty),
    .credit_o    (req_credit_o)
  );

  // ----------------------------------------
  // Processing
  // ----------------------------------------
  alu_datapath u_datapath (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_head_i      (req_head),
    .req_not_empty_i (req_not_empty),
    .req_pop_o       (req_pop),
    .slot_credit_i   (slot_credit),
    .res_push_o      (res_push),
    .res_data_o      (res_data)
  );

  // Output side
  alu_egress u_egress (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .res_push_i    (res_push),
    .res_data_i    (res_data),
    .slot_credit_o (slot_credit),
    .res_credit_i  (res_credit_i),
    .res_valid_o   (res_valid_o),
    .res_data_o    (res_data_o),
    .res_branch_o  (res_branch_o),
    .res_tag_o     (res_tag_o)
  );

endmodule

//--- verilog/credit_fifo.sv
// Circular queue for any payload type, returning one credit per popped entry
module credit_fifo
  import alu_pkg::*;
#(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     not_empty_o,
  output logic     credit_o
);

  payload_t                 mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [CNT_W-1:0]         count;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // One credit back to the sender for every slot freed
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop_i;
    end
  end

  assign head_o      = mem[rd_ptr];
  assign not_empty_o = (count != '0);

endmodule
